//--- cps_mem.f
cps_mem_pkg.sv
cps_timing_pkg.sv
cps_cen_gen.sv
cps_prom_we.sv
cps_sdram_mux.sv
cps_mem_top.sv
tb_sdram_model.sv
tb_cps_mem.sv

//--- Bender.yml
package:
  name: cps_mem

sources:
  - cps_mem_pkg.sv
  - cps_timing_pkg.sv
  - cps_cen_gen.sv
  - cps_prom_we.sv
  - cps_sdram_mux.sv
  - cps_mem_top.sv
  - target: test
    files:
      - tb_sdram_model.sv
      - tb_cps_mem.sv

//--- tb_cps_mem.sv
// CPS memory subsystem testbench
// Runs the clock enables, the ROM download writer and the SDRAM slot mux
// against reference functions, with an SDRAM controller model beside the DUT
`timescale 1ns/1ns

module tb_cps_mem;
    import cps_mem_pkg::*;
    import cps_timing_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles before a wait gives up

    typedef struct packed {
        slot_id_e            slot;
        logic                rnw;
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          wrmask;
        logic [15:0]         data;
    } exp_acc_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                downloading;
    logic [22:0]         ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    slot_req_t           slot_req [NUM_SLOTS];
    slot_rsp_t           slot_rsp [NUM_SLOTS];
    logic                sdram_ack;
    logic                data_rdy;
    logic [31:0]         data_read;
    logic                cpu_cen;
    logic                pxl_cen;
    logic [SDRAM_AW-1:0] prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    sdram_cmd_t          sdram;
    logic                refresh_en;
    logic                acc_vld;
    logic                acc_prog;
    sdram_cmd_t          acc;

    exp_acc_t    dl_q [$];    // Download bytes not yet written
    exp_acc_t    exp_q [$];   // Client accesses not yet seen at SDRAM
    exp_acc_t    done_q [$];  // Seen at SDRAM, ok still due
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          err_mark = 0;
    int          ok_cnt [NUM_SLOTS];
    int          total;
    int          t;
    int          cpu_n;
    int          pxl_n;
    logic [22:0] byte_addr;
    logic [7:0]  byte_val;
    logic [15:0] lfsr = 16'd9057;

    always #2 clk = ~clk;

    cps_mem_top cps_mem_top_i (.*);
    tb_sdram_model sdram_model_i (.*);

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [SDRAM_AW-1:0] expect_addr(input slot_id_e s, input logic vsel,
                                                        input logic [19:0] a);
        logic [SDRAM_AW-1:0] base;
        if (s == SLOT_MAIN_ROM) base = ROM_OFFSET;
        else if (s == SLOT_GFX) base = GFX_OFFSET;
        else if (s == SLOT_VRAM || vsel) base = VRAM_OFFSET;
        else base = RAM_OFFSET;
        return base + SDRAM_AW'(a);
    endfunction

    function automatic logic [31:0] expect_read(input logic [SDRAM_AW-1:0] a);
        return {a[21:6], a[15:0]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic [1:0] expect_mask(input logic [22:0] a);
        return a[0] ? 2'b01 : 2'b10;  // Odd byte is the high half
    endfunction

    function automatic int expect_cen_count(input int cycles, input int n, input int m);
        return cycles * n / m;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("error %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic give_up(input string what);
        $display("timeout waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - err_mark);
        err_mark = err_cnt;
    endtask

    task automatic start_access(input slot_id_e s, input logic wr, input logic vsel,
                                input logic [19:0] a, input logic [15:0] d,
                                input logic [1:0] m);
        exp_q.push_back(exp_acc_t'{slot: s, rnw: !wr, addr: expect_addr(s, vsel, a),
                                   wrmask: m, data: d});
        slot_req[s] <= '{cs: 1'b1, wr: wr, vram_sel: vsel, addr: a, din: d, wrmask: m};
    endtask

    task automatic wait_ok(input slot_id_e s);
        int n;
        n = 0;
        @(posedge clk);
        while (!slot_rsp[s].ok && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!slot_rsp[s].ok) give_up($sformatf("ok on slot %0d", s));
        slot_req[s].cs <= 1'b0;  // Drop cs the cycle after ok
    endtask

    task automatic count_oks();
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_rsp[i].ok) begin
                ok_cnt[i]++;
                total++;
                slot_req[i].cs <= 1'b0;
            end
        end
    endtask

    // Compares every SDRAM access and every ok against the expected queues
    always @(posedge clk) begin
        exp_acc_t e;
        if (acc_vld && acc_prog) begin
            assert (dl_q.size() > 0) else note_failure("programming write with no byte sent");
            if (dl_q.size() > 0) begin
                e = dl_q.pop_front();
                check_value("prog_addr", acc.addr, e.addr);
                check_value("prog_mask", acc.wrmask, e.wrmask);
                check_value("prog_data", acc.data_write[7:0], e.data[7:0]);
            end
        end else if (acc_vld) begin
            assert (exp_q.size() > 0) else note_failure("SDRAM access with no client request");
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_value("sdram.addr", acc.addr, e.addr);
                check_value("sdram.rnw", acc.rnw, e.rnw);
                if (!e.rnw) begin
                    check_value("sdram.wrmask", acc.wrmask, e.wrmask);
                    check_value("sdram.data_write", acc.data_write, e.data);
                end
                done_q.push_back(e);
            end
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_rsp[i].ok) begin
                assert (done_q.size() > 0) else note_failure("ok with no SDRAM access done");
                if (done_q.size() > 0) begin
                    e = done_q.pop_front();
                    check_value("ok slot", i, e.slot);
                    if (e.rnw && e.slot == SLOT_GFX) begin
                        check_value("slot_rsp[3].dout", slot_rsp[i].dout, expect_read(e.addr));
                    end else if (e.rnw) begin
                        check_value($sformatf("slot_rsp[%0d].dout", i),
                                    {16'h0, slot_rsp[i].dout[15:0]},
                                    expect_read(e.addr) & 32'h0000_FFFF);
                    end
                end
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_req[i] = '0;
            ok_cnt[i]   = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // First sample after reset still shows the reset value
        @(posedge clk);
        cpu_n = 0;
        pxl_n = 0;
        repeat (240) begin
            @(posedge clk);
            cpu_n += cpu_cen;
            pxl_n += pxl_cen;
        end
        check_value("cpu_cen count", cpu_n, expect_cen_count(240, CPU_CEN_N, CPU_CEN_M));
        check_value("pxl_cen count", pxl_n, expect_cen_count(240, 1, PXL_DIV));
        finish_test("clock enables");

        downloading <= 1'b1;
        for (int k = 0; k < 8; k++) begin
            byte_addr = 23'(rand_bits(23));
            byte_val  = 8'(rand_bits(8));
            dl_q.push_back(exp_acc_t'{slot: SLOT_MAIN_ROM, rnw: 1'b0,
                                      addr: SDRAM_AW'(byte_addr >> 1),
                                      wrmask: expect_mask(byte_addr), data: {8'h00, byte_val}});
            ioctl_addr <= byte_addr;
            ioctl_data <= byte_val;
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            t = 0;
            @(posedge clk);
            while (prog_we && t < WAIT_LIMIT) begin  // Held until the model acks
                @(posedge clk);
                t++;
            end
            if (prog_we) give_up("prog_we to clear");
        end
        downloading <= 1'b0;
        assert (dl_q.size() == 0) else note_failure("download byte never written");
        finish_test("download");

        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                start_access(slot_id_e'(s), 1'b0, 1'(rand_bits(1)), 20'(rand_bits(20)),
                             16'h0000, 2'b11);
                wait_ok(slot_id_e'(s));
            end
        end
        finish_test("single reads");

        for (int k = 0; k < 6; k++) begin
            start_access(SLOT_MAIN_RAM, 1'b1, 1'(rand_bits(1)), 20'(rand_bits(16)),
                         16'(rand_bits(16)), 2'(rand_bits(2)));
            wait_ok(SLOT_MAIN_RAM);
        end
        finish_test("RAM writes");

        // All four clients raised together so the lowest slot goes first
        for (int s = 0; s < NUM_SLOTS; s++) begin
            start_access(slot_id_e'(s), 1'b0, 1'b0, 20'(rand_bits(16)), 16'h0000, 2'b11);
        end
        total = 0;
        t     = 0;
        while (total < NUM_SLOTS && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
            count_oks();
        end
        if (total < NUM_SLOTS) give_up("ok on all four slots");
        repeat (10) begin
            @(posedge clk);
            count_oks();
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            check_value($sformatf("ok count slot %0d", s), ok_cnt[s], 1);
        end
        check_value("refresh_en", refresh_en, 1'b1);  // Idle with no client waiting
        finish_test("priority");

        downloading <= 1'b1;
        start_access(SLOT_VRAM, 1'b0, 1'b0, 20'(rand_bits(16)), 16'h0000, 2'b11);
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            check_cnt++;
            assert (!sdram.req) else note_failure("SDRAM request started while downloading");
            if (c > 0) begin
                check_value("refresh_en", refresh_en, 1'b0);  // Lags downloading by one cycle
            end
        end
        downloading <= 1'b0;
        wait_ok(SLOT_VRAM);
        finish_test("download blocking");

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
// SDRAM controller model for the CPS memory testbench
// Serves the mux command, or the programming write while downloading
// Ack and read data come after random delays of 1 to 4 cycles
// Every served access is reported once on the acc outputs
`timescale 1ns/1ns

module tb_sdram_model (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             downloading,
    input  cps_mem_pkg::sdram_cmd_t          sdram,
    input  logic                             prog_we,
    input  logic [cps_mem_pkg::SDRAM_AW-1:0] prog_addr,
    input  logic [7:0]                       prog_data,
    input  logic [1:0]                       prog_mask,
    output logic                             sdram_ack,
    output logic                             data_rdy,
    output logic [31:0]                      data_read,
    output logic                             acc_vld,
    output logic                             acc_prog,
    output cps_mem_pkg::sdram_cmd_t          acc
);
    import cps_mem_pkg::*;

    typedef enum logic [1:0] {M_IDLE, M_ACK, M_DATA, M_DONE} model_state_e;

    model_state_e state;
    logic [2:0]   cnt;
    logic [15:0]  lfsr = 16'd9057;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Stored word seen at an address
    function automatic logic [31:0] read_word(input logic [SDRAM_AW-1:0] a);
        return {a[21:6], a[15:0]} ^ 32'h5A3C_96E1;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= M_IDLE;
            cnt       <= '0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            acc_vld   <= 1'b0;
            acc_prog  <= 1'b0;
            acc       <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            acc_vld   <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (downloading ? prog_we : sdram.req) begin
                        acc_prog <= downloading;
                        acc      <= downloading ? sdram_cmd_t'{req: 1'b1, addr: prog_addr,
                                    rnw: 1'b0, wrmask: prog_mask,
                                    data_write: {8'h00, prog_data}} : sdram;
                        cnt      <= 3'(rand_bits(2)) + 3'd1;
                        state    <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (cnt == 3'd1) begin
                        sdram_ack <= 1'b1;
                        acc_vld   <= 1'b1;
                        cnt       <= 3'(rand_bits(2)) + 3'd1;  // Read data delay
                        state     <= acc.rnw ? M_DATA : M_DONE;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                M_DATA: begin
                    if (cnt == 3'd1) begin
                        data_rdy  <= 1'b1;
                        data_read <= read_word(acc.addr);
                        state     <= M_IDLE;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                default: state <= M_IDLE;  // Requester drops its level here
            endcase
        end
    end

endmodule

//--- cps_mem_top.sv
// CPS memory subsystem top level
// Ties together the clock enables, the ROM download writer and the
// SDRAM slot mux that serves the main CPU and video clients
`timescale 1ns/1ns

module cps_mem_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             downloading,
    // ROM download
    input  logic [22:0]                      ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    input  logic                             ioctl_wr,
    // Memory clients
    input  cps_mem_pkg::slot_req_t           slot_req [cps_mem_pkg::NUM_SLOTS],
    // SDRAM controller side
    input  logic                             sdram_ack,
    input  logic                             data_rdy,
    input  logic [31:0]                      data_read,
    output logic                             cpu_cen,
    output logic                             pxl_cen,
    output logic [cps_mem_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                       prog_data,
    output logic [1:0]                       prog_mask,
    output logic                             prog_we,
    output cps_mem_pkg::slot_rsp_t           slot_rsp [cps_mem_pkg::NUM_SLOTS],
    output cps_mem_pkg::sdram_cmd_t          sdram,
    output logic                             refresh_en
);

    cps_cen_gen cps_cen_gen_i (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cpu_cen ( cpu_cen ),
        .pxl_cen ( pxl_cen )
    );

    cps_prom_we cps_prom_we_i (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),  // Shared ack, served by prog_we while downloading
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

    cps_sdram_mux cps_sdram_mux_i (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .slot_req    ( slot_req    ),
        .slot_rsp    ( slot_rsp    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .sdram       ( sdram       ),
        .refresh_en  ( refresh_en  )
    );

endmodule

//--- cps_sdram_mux.sv
// CPS SDRAM slot multiplexer
// Fixed priority arbiter over four clients, lowest slot wins
// Adds the region base to the slot address and runs one SDRAM access
// at a time through request, ack and read data phases
`timescale 1ns/1ns

module cps_sdram_mux (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    downloading,
    input  cps_mem_pkg::slot_req_t  slot_req [cps_mem_pkg::NUM_SLOTS],
    output cps_mem_pkg::slot_rsp_t  slot_rsp [cps_mem_pkg::NUM_SLOTS],
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    input  logic [31:0]             data_read,
    output cps_mem_pkg::sdram_cmd_t sdram,
    output logic                    refresh_en
);
    import cps_mem_pkg::*;

    mux_state_e           state;
    slot_id_e             cur_slot;  // Slot being served
    slot_id_e             pick;
    logic                 pick_vld;
    logic                 any_cs;
    logic                 start;
    logic [NUM_SLOTS-1:0] ok_q;
    logic                 req_q;
    logic [SDRAM_AW-1:0]  addr_q;
    logic                 rnw_q;
    logic [1:0]           wrmask_q;
    logic [15:0]          wdata_q;
    logic [31:0]          dout_q [NUM_SLOTS];

    function automatic logic [SDRAM_AW-1:0] slot_offset(input slot_id_e id,
                                                        input logic vram_sel);
        logic [SDRAM_AW-1:0] base;
        case (id)
            SLOT_MAIN_ROM: base = ROM_OFFSET;
            SLOT_MAIN_RAM: base = vram_sel ? VRAM_OFFSET : RAM_OFFSET;
            SLOT_VRAM:     base = VRAM_OFFSET;
            default:       base = GFX_OFFSET;
        endcase
        return base;
    endfunction

    // Scan downwards so the lowest eligible slot is the last one kept
    always_comb begin
        pick_vld = 1'b0;
        pick     = SLOT_MAIN_ROM;
        any_cs   = 1'b0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            any_cs = any_cs | slot_req[i].cs;
            if (slot_req[i].cs && !ok_q[i]) begin  // Skip a slot in its ok cycle
                pick_vld = 1'b1;
                pick     = slot_id_e'(i);
            end
        end
    end

    assign start = state == MUX_IDLE && pick_vld && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= MUX_IDLE;
            cur_slot   <= SLOT_MAIN_ROM;
            req_q      <= 1'b0;
            ok_q       <= '0;
            refresh_en <= 1'b0;
        end else begin
            ok_q       <= '0;  // ok is a single cycle pulse
            refresh_en <= state == MUX_IDLE && !any_cs && !downloading;
            case (state)
                MUX_IDLE: begin
                    if (start) begin
                        cur_slot <= pick;
                        req_q    <= 1'b1;
                        state    <= MUX_WAIT_ACK;
                    end
                end
                MUX_WAIT_ACK: begin
                    if (sdram_ack) begin
                        req_q <= 1'b0;
                        if (rnw_q) begin
                            state <= MUX_WAIT_DATA;
                        end else begin
                            ok_q[cur_slot] <= 1'b1;  // Write done at ack
                            state          <= MUX_IDLE;
                        end
                    end
                end
                MUX_WAIT_DATA: begin
                    if (data_rdy) begin
                        ok_q[cur_slot] <= 1'b1;
                        state          <= MUX_IDLE;
                    end
                end
                default: state <= MUX_IDLE;
            endcase
        end
    end

    // Latched access and read data
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q   <= slot_offset(pick, slot_req[pick].vram_sel)
                        + SDRAM_AW'(slot_req[pick].addr);
            rnw_q    <= !(slot_req[pick].wr && pick == SLOT_MAIN_RAM);
            wrmask_q <= slot_req[pick].wrmask;
            wdata_q  <= slot_req[pick].din;
        end
        if (state == MUX_WAIT_DATA && data_rdy) begin
            dout_q[cur_slot] <= data_read;  // Held until next read on this slot
        end
    end

    assign sdram = '{req: req_q, addr: addr_q, rnw: rnw_q,
                     wrmask: wrmask_q, data_write: wdata_q};

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_rsp[i] = '{ok: ok_q[i], dout: dout_q[i]};
        end
    end

    a_ok_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ok_q));

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram.req && !sdram_ack |=> sdram.req);

    // Download owns the SDRAM
    a_no_dl_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram.req) |-> $past(!downloading));

endmodule

//--- cps_prom_we.sv
// CPS ROM download writer
// Turns each download byte into a 16-bit SDRAM programming write
// Even byte goes to the low half and odd byte to the high half
// The write request is held until the SDRAM controller acks it
`timescale 1ns/1ns

module cps_prom_we (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            downloading,
    input  logic [22:0]                     ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  logic                            ioctl_wr,
    input  logic                            sdram_ack,
    output logic [cps_mem_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                      prog_data,
    output logic [1:0]                      prog_mask,
    output logic                            prog_we
);

    logic byte_in;

    assign byte_in = ioctl_wr && downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we   <= 1'b0;
            prog_mask <= 2'b11;  // Both bytes masked
        end else if (byte_in) begin
            prog_we   <= 1'b1;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end else if (sdram_ack) begin
            prog_we   <= 1'b0;
        end
    end

    // Byte payload
    always_ff @(posedge clk) begin
        if (byte_in) begin
            prog_addr <= ioctl_addr[22:1];  // Byte to word address
            prog_data <= ioctl_data;
        end
    end

    // Downloader must pace its bytes behind the SDRAM ack
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl_wr |-> !prog_we);

endmodule

//--- cps_cen_gen.sv
// CPS clock enable generator
// Fractional accumulator gives evenly spread CPU enables at N/M of clk
// A modulo counter gives the pixel enable
`timescale 1ns/1ns

module cps_cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic cpu_cen,
    output logic pxl_cen
);
    import cps_timing_pkg::*;

    logic [CEN_CNT_W-1:0] acc;
    logic [CEN_CNT_W:0]   acc_sum;  // One spare bit for the carry
    logic [CEN_CNT_W-1:0] pxl_cnt;

    assign acc_sum = {1'b0, acc} + (CEN_CNT_W+1)'(CPU_CEN_N);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            cpu_cen <= 1'b0;
        end else if (acc_sum >= (CEN_CNT_W+1)'(CPU_CEN_M)) begin
            acc     <= CEN_CNT_W'(acc_sum - (CEN_CNT_W+1)'(CPU_CEN_M)); // Wrap
            cpu_cen <= 1'b1;
        end else begin
            acc     <= CEN_CNT_W'(acc_sum);
            cpu_cen <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= pxl_cnt == CEN_CNT_W'(PXL_DIV - 1);
            pxl_cnt <= (pxl_cnt == CEN_CNT_W'(PXL_DIV - 1)) ? '0 : pxl_cnt + 1'b1;
        end
    end

    a_pxl_single: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen |=> !pxl_cen);

endmodule

//--- cps_timing_pkg.sv
// CPS clock enable settings
// CPU enable runs at a fractional ratio of clk
// Pixel enable is an integer division of clk
package cps_timing_pkg;

    // CPU enable at N/M of clk
    localparam int CPU_CEN_N = 5;
    localparam int CPU_CEN_M = 24;

    // Pixel enable once every PXL_DIV clocks
    localparam int PXL_DIV = 6;

    // Wide enough for the accumulator and the pixel counter
    localparam int CEN_CNT_W = $clog2(CPU_CEN_M + 1);

endpackage

//--- cps_mem_pkg.sv
// CPS memory map package
// SDRAM region bases, client slot identifiers and the request, response
// and SDRAM command records shared by the slot mux and its clients
// Slot enum order doubles as the arbitration priority
package cps_mem_pkg;

    localparam int SDRAM_AW  = 22;  // SDRAM word address
    localparam int NUM_SLOTS = 4;

    // Region bases in SDRAM words
    localparam logic [SDRAM_AW-1:0] ROM_OFFSET  = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET  = 22'h0A_8000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET  = 22'h3A_8000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET = 22'h3B_0000;

    typedef enum logic [1:0] {
        SLOT_MAIN_ROM,  // Highest priority
        SLOT_MAIN_RAM,  // Only slot allowed to write
        SLOT_VRAM,
        SLOT_GFX        // 32-bit reads
    } slot_id_e;

    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_WAIT_ACK,
        MUX_WAIT_DATA
    } mux_state_e;

    typedef struct packed {
        logic        cs;        // Held until ok
        logic        wr;
        logic        vram_sel;  // RAM slot picks VRAM region
        logic [19:0] addr;      // Word address inside region
        logic [15:0] din;
        logic [1:0]  wrmask;    // Active low byte masks
    } slot_req_t;

    typedef struct packed {
        logic        ok;        // One cycle pulse
        logic [31:0] dout;      // 16-bit clients use 15:0
    } slot_rsp_t;

    typedef struct packed {
        logic                req;   // Level until sdram_ack
        logic [SDRAM_AW-1:0] addr;
        logic                rnw;
        logic [1:0]          wrmask;
        logic [15:0]         data_write;
    } sdram_cmd_t;

endpackage
